/* logic/panel_pkg.sv */
package panel_pkg;

  // ************************************************************
  // Types
  // ************************************************************
  typedef logic [6:0]  glyph_t;   // Active low segments g..a
  typedef logic [9:0]  leds_t;
  typedef logic [31:0] word_t;

  localparam int NUM_REGS = 32;

  typedef logic [4:0] reg_idx_t;
  typedef word_t [NUM_REGS-1:0] reg_bank_t;

  typedef struct packed {
    glyph_t d6;                   // Leftmost letter
    glyph_t d5;
    glyph_t d4;
    glyph_t d3;
  } banner_word_t;

  // ************************************************************
  // Glyphs
  // ************************************************************
  localparam glyph_t GLYPH_BLANK = 7'b1111111;
  localparam glyph_t GLYPH_C     = 7'b1000110;
  localparam glyph_t GLYPH_N     = 7'b0101011;   // Lower case n
  localparam glyph_t GLYPH_J     = 7'b1100001;
  localparam glyph_t GLYPH_U     = 7'b1000001;
  localparam glyph_t GLYPH_S     = 7'b0010010;
  localparam glyph_t GLYPH_T     = 7'b0000111;   // Lower case t
  localparam glyph_t GLYPH_P     = 7'b0001100;
  localparam glyph_t GLYPH_B     = 7'b0000011;   // Lower case b
  localparam glyph_t GLYPH_R     = 7'b0101111;   // Lower case r
  localparam glyph_t GLYPH_O     = 7'b0100011;   // Lower case o

  function automatic glyph_t hex_glyph(input logic [3:0] nibble);
    case (nibble)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0011000;
      4'ha: return 7'b0001000;
      4'hb: return 7'b0000011;
      4'hc: return 7'b1000110;
      4'hd: return 7'b0100001;
      4'he: return 7'b0000110;
      default: return 7'b0001110;   // F
    endcase
  endfunction

  // Digits above 9 show nothing
  function automatic glyph_t dec_glyph(input logic [3:0] digit);
    return (digit <= 4'd9) ? hex_glyph(digit) : GLYPH_BLANK;
  endfunction

  // ************************************************************
  // Sequence tables
  // ************************************************************
  localparam banner_word_t BANNER_WORDS [3] = '{
    '{GLYPH_J, GLYPH_U, GLYPH_S, GLYPH_T},
    '{GLYPH_C, GLYPH_P, GLYPH_U, GLYPH_BLANK},
    '{GLYPH_B, GLYPH_R, GLYPH_O, GLYPH_BLANK}
  };

  localparam leds_t LED_SHOW [22] = '{
    10'b1010101010, 10'b0101010101, 10'b1010101010, 10'b0101010101,
    10'b1010101010, 10'b0000000000, 10'b1111111111, 10'b0000000000,
    10'b1111111111, 10'b1000000001, 10'b0100000010, 10'b0010000100,
    10'b0001001000, 10'b0000110000, 10'b1000110001, 10'b0100110010,
    10'b0010110100, 10'b0001111000, 10'b1001111001, 10'b0101111010,
    10'b0011111100, 10'b0111111110
  };

  localparam leds_t LED_WALK [10] = '{
    10'b1000000000, 10'b0100000000, 10'b0010000000, 10'b0001000000,
    10'b0000100000, 10'b0000010000, 10'b0000001000, 10'b0000000100,
    10'b0000000010, 10'b0000000001
  };

endpackage

/* logic/panel_if.sv */
interface panel_if import panel_pkg::*; ();

  // One full picture for the board
  glyph_t digit_1;   // Rightmost digit
  glyph_t digit_2;
  glyph_t digit_3;
  glyph_t digit_4;
  glyph_t digit_5;
  glyph_t digit_6;   // Leftmost digit
  leds_t  leds;

  modport source (
    output digit_1, digit_2, digit_3, digit_4, digit_5, digit_6,
    output leds
  );

  modport sink (
    input digit_1, digit_2, digit_3, digit_4, digit_5, digit_6,
    input leds
  );

endinterface

/* logic/step_sequencer.sv */
module step_sequencer import panel_pkg::*; #(
  parameter type payload_t = leds_t,
  parameter int N_STEPS = 2,
  parameter int STEP_CYCLES = 1,
  parameter payload_t STEPS [N_STEPS] = '{default: '0}
) (
  input  logic     clk,
  input  logic     reset,
  output payload_t step
);

  localparam int SLOT_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;
  localparam int IDX_W  = (N_STEPS > 1) ? $clog2(N_STEPS) : 1;

  logic [SLOT_W-1:0] slot;       // Cycles spent in current step
  logic [IDX_W-1:0]  idx;        // Current table entry
  logic [IDX_W-1:0]  next_idx;
  logic              slot_end;

  assign slot_end = (slot == SLOT_W'(STEP_CYCLES - 1));
  assign next_idx = (idx == IDX_W'(N_STEPS - 1)) ? '0 : idx + 1'b1;   // Wrap after last

  always_ff @(posedge clk) begin
    if (!reset) begin
      slot <= '0;
      idx  <= '0;
      step <= STEPS[0];            // Entry 0 ready for first cycle
    end else if (slot_end) begin
      slot <= '0;
      idx  <= next_idx;
      step <= STEPS[next_idx];
    end else begin
      slot <= slot + 1'b1;
    end
  end

endmodule

/* logic/readout_panel.sv */
module readout_panel import panel_pkg::*; #(
  parameter int LED_STEP_CYCLES = 10000000
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      show_cycles,
  input  logic      upper_half,
  input  reg_idx_t  reg_sel,
  input  reg_bank_t reg_bank,
  input  word_t     cycle_count,
  panel_if.source   pic
);

  word_t       shown;        // Register or cycle count
  logic [15:0] half;
  logic [3:0]  idx_units;
  logic [3:0]  idx_tens;     // 0 to 3 for 32 registers
  leds_t       walk;

  // ************************************************************
  // Value selection
  // ************************************************************
  assign shown = show_cycles ? cycle_count : reg_bank[reg_sel];
  assign half  = upper_half ? shown[31:16] : shown[15:0];

  assign idx_units = 4'(reg_sel % 5'd10);
  assign idx_tens  = 4'(reg_sel / 5'd10);

  // ************************************************************
  // Glyph registers
  // ************************************************************
  always_ff @(posedge clk) begin
    pic.digit_1 <= hex_glyph(half[3:0]);     // Least significant nibble
    pic.digit_2 <= hex_glyph(half[7:4]);
    pic.digit_3 <= hex_glyph(half[11:8]);
    pic.digit_4 <= hex_glyph(half[15:12]);
    if (show_cycles) begin
      pic.digit_5 <= GLYPH_N;                // Reads "C n"
      pic.digit_6 <= GLYPH_C;
    end else begin
      pic.digit_5 <= dec_glyph(idx_units);
      pic.digit_6 <= dec_glyph(idx_tens);
    end
  end

  // Single LED running from left to right
  step_sequencer #(
    .payload_t   (leds_t),
    .N_STEPS     (10),
    .STEP_CYCLES (LED_STEP_CYCLES),
    .STEPS       (LED_WALK)
  ) u_walk (
    .clk   (clk),
    .reset (reset),
    .step  (walk)
  );

  assign pic.leds = walk;   // Already registered in sequencer

endmodule

/* logic/banner_panel.sv */
module banner_panel import panel_pkg::*; #(
  parameter int BANNER_STEP_CYCLES = 75000000,
  parameter int LED_STEP_CYCLES    = 10000000
) (
  input  logic    clk,
  input  logic    reset,
  panel_if.source pic
);

  banner_word_t word;
  leds_t        show;

  // ************************************************************
  // Sequencers
  // ************************************************************
  step_sequencer #(
    .payload_t   (banner_word_t),
    .N_STEPS     (3),
    .STEP_CYCLES (BANNER_STEP_CYCLES),
    .STEPS       (BANNER_WORDS)
  ) u_words (
    .clk   (clk),
    .reset (reset),
    .step  (word)
  );

  step_sequencer #(
    .payload_t   (leds_t),
    .N_STEPS     (22),
    .STEP_CYCLES (LED_STEP_CYCLES),
    .STEPS       (LED_SHOW)
  ) u_show (
    .clk   (clk),
    .reset (reset),
    .step  (show)
  );

  // Word sits on the four left digits
  assign pic.digit_6 = word.d6;
  assign pic.digit_5 = word.d5;
  assign pic.digit_4 = word.d4;
  assign pic.digit_3 = word.d3;
  assign pic.digit_2 = GLYPH_BLANK;   // Right pair stays dark
  assign pic.digit_1 = GLYPH_BLANK;

  assign pic.leds = show;

endmodule

/* logic/panel_mux.sv */
module panel_mux import panel_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   run_mode,
  panel_if.sink  readout_pic,
  panel_if.sink  banner_pic,
  output glyph_t digit_1,
  output glyph_t digit_2,
  output glyph_t digit_3,
  output glyph_t digit_4,
  output glyph_t digit_5,
  output glyph_t digit_6,
  output leds_t  leds
);

  always_ff @(posedge clk) begin
    if (!reset) begin
      digit_1 <= GLYPH_BLANK;   // Panel dark in reset
      digit_2 <= GLYPH_BLANK;
      digit_3 <= GLYPH_BLANK;
      digit_4 <= GLYPH_BLANK;
      digit_5 <= GLYPH_BLANK;
      digit_6 <= GLYPH_BLANK;
      leds    <= '0;
    end else if (run_mode) begin
      digit_1 <= readout_pic.digit_1;
      digit_2 <= readout_pic.digit_2;
      digit_3 <= readout_pic.digit_3;
      digit_4 <= readout_pic.digit_4;
      digit_5 <= readout_pic.digit_5;
      digit_6 <= readout_pic.digit_6;
      leds    <= readout_pic.leds;
    end else begin
      digit_1 <= banner_pic.digit_1;
      digit_2 <= banner_pic.digit_2;
      digit_3 <= banner_pic.digit_3;
      digit_4 <= banner_pic.digit_4;
      digit_5 <= banner_pic.digit_5;
      digit_6 <= banner_pic.digit_6;
      leds    <= banner_pic.leds;
    end
  end

endmodule

/* logic/debug_panel_top.sv */
module debug_panel_top import panel_pkg::*; #(
  parameter int BANNER_STEP_CYCLES = 75000000,   // Time per banner word
  parameter int LED_STEP_CYCLES    = 10000000    // Time per LED step
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      run_mode,      // High for readout
  input  logic      show_cycles,
  input  logic      upper_half,
  input  reg_idx_t  reg_sel,
  input  reg_bank_t reg_bank,
  input  word_t     cycle_count,
  output glyph_t    digit_1,
  output glyph_t    digit_2,
  output glyph_t    digit_3,
  output glyph_t    digit_4,
  output glyph_t    digit_5,
  output glyph_t    digit_6,
  output leds_t     leds
);

  // ************************************************************
  // Pictures
  // ************************************************************
  panel_if readout_pic ();
  panel_if banner_pic ();

  readout_panel #(
    .LED_STEP_CYCLES (LED_STEP_CYCLES)
  ) u_readout (
    .clk         (clk),
    .reset       (reset),
    .show_cycles (show_cycles),
    .upper_half  (upper_half),
    .reg_sel     (reg_sel),
    .reg_bank    (reg_bank),
    .cycle_count (cycle_count),
    .pic         (readout_pic.source)
  );

  banner_panel #(
    .BANNER_STEP_CYCLES (BANNER_STEP_CYCLES),
    .LED_STEP_CYCLES    (LED_STEP_CYCLES)
  ) u_banner (
    .clk   (clk),
    .reset (reset),
    .pic   (banner_pic.source)
  );

  // ************************************************************
  // Output stage
  // ************************************************************
  panel_mux u_mux (
    .clk         (clk),
    .reset       (reset),
    .run_mode    (run_mode),
    .readout_pic (readout_pic.sink),
    .banner_pic  (banner_pic.sink),
    .digit_1     (digit_1),
    .digit_2     (digit_2),
    .digit_3     (digit_3),
    .digit_4     (digit_4),
    .digit_5     (digit_5),
    .digit_6     (digit_6),
    .leds        (leds)
  );

endmodule

/* verif/debug_panel_properties.sv */
module debug_panel_properties import panel_pkg::*; (
  input logic   clk,
  input logic   reset,
  input logic   run_mode,
  input glyph_t digit_1,
  input glyph_t digit_2,
  input glyph_t digit_3,
  input glyph_t digit_4,
  input glyph_t digit_5,
  input glyph_t digit_6,
  input leds_t  leds
);

  int assert_failures = 0;

  // ************************************************************
  // Panel output rules
  // ************************************************************
  assert property (@(posedge clk) !reset |=>
                   (digit_1 == GLYPH_BLANK) && (digit_2 == GLYPH_BLANK) &&
                   (digit_3 == GLYPH_BLANK) && (digit_4 == GLYPH_BLANK) &&
                   (digit_5 == GLYPH_BLANK) && (digit_6 == GLYPH_BLANK) &&
                   (leds == '0))
    else begin
      assert_failures++;
      $error("panel not blank and dark after a reset cycle");
    end

  // Walk always lights a single LED
  assert property (@(posedge clk) disable iff (!reset)
                   run_mode && $past(run_mode) |=> $onehot(leds))
    else begin
      assert_failures++;
      $error("readout mode LEDs not one-hot");
    end

  assert property (@(posedge clk) disable iff (!reset)
                   !run_mode && $past(!run_mode) |=>
                   (digit_1 == GLYPH_BLANK) && (digit_2 == GLYPH_BLANK))
    else begin
      assert_failures++;
      $error("banner mode right digits not blank");
    end

endmodule

bind panel_mux debug_panel_properties u_props (
  .clk      (clk),
  .reset    (reset),
  .run_mode (run_mode),
  .digit_1  (digit_1),
  .digit_2  (digit_2),
  .digit_3  (digit_3),
  .digit_4  (digit_4),
  .digit_5  (digit_5),
  .digit_6  (digit_6),
  .leds     (leds)
);

/* verif/debug_panel_tb.sv */
module debug_panel_tb import panel_pkg::*; ();

  localparam int CLK_PERIOD  = 40;
  localparam int BANNER_STEP = 12;   // Cycles per banner word
  localparam int LED_STEP    = 4;    // Cycles per LED step
  localparam int N_ROWS      = 14;

  typedef struct packed {
    logic       run_mode;
    logic       show_cycles;
    logic       upper_half;
    reg_idx_t   reg_sel;
    word_t      cycle_count;
    logic [7:0] hold;        // At least 2 cycles
  } row_t;

  // ************************************************************
  // Stimulus table
  // ************************************************************
  localparam row_t ROWS [N_ROWS] = '{
    '{1'b1, 1'b0, 1'b0, 5'd0,  32'h0000_0000, 8'd6},
    '{1'b1, 1'b0, 1'b0, 5'd9,  32'h0000_0000, 8'd6},
    '{1'b1, 1'b0, 1'b0, 5'd10, 32'h0000_0000, 8'd6},
    '{1'b1, 1'b0, 1'b0, 5'd31, 32'h0000_0000, 8'd6},
    '{1'b1, 1'b0, 1'b1, 5'd31, 32'h0000_0000, 8'd6},
    '{1'b1, 1'b0, 1'b1, 5'd5,  32'h0000_0000, 8'd5},
    '{1'b1, 1'b1, 1'b0, 5'd17, 32'hdead_beef, 8'd6},
    '{1'b1, 1'b1, 1'b1, 5'd17, 32'hdead_beef, 8'd6},
    '{1'b1, 1'b1, 1'b0, 5'd3,  32'h0001_f00d, 8'd5},
    '{1'b0, 1'b0, 1'b0, 5'd0,  32'h0000_0000, 8'd40},   // All three words
    '{1'b1, 1'b0, 1'b0, 5'd22, 32'h0000_0000, 8'd45},   // Full walk and wrap
    '{1'b0, 1'b1, 1'b1, 5'd7,  32'h1234_5678, 8'd12},
    '{1'b1, 1'b0, 1'b1, 5'd12, 32'h0000_0000, 8'd8},
    '{1'b1, 1'b1, 1'b1, 5'd0,  32'hcafe_0042, 8'd4}
  };

  logic      clk;
  logic      reset;
  logic      run_mode;
  logic      show_cycles;
  logic      upper_half;
  reg_idx_t  reg_sel;
  reg_bank_t reg_bank;
  word_t     cycle_count;
  glyph_t    digit_1;
  glyph_t    digit_2;
  glyph_t    digit_3;
  glyph_t    digit_4;
  glyph_t    digit_5;
  glyph_t    digit_6;
  leds_t     leds;

  int seed;
  int cycles_since_reset;   // Clocks since reset release
  int checks;
  int errors;
  int row_errors;

  debug_panel_top #(
    .BANNER_STEP_CYCLES (BANNER_STEP),
    .LED_STEP_CYCLES    (LED_STEP)
  ) dut (
    .clk         (clk),
    .reset       (reset),
    .run_mode    (run_mode),
    .show_cycles (show_cycles),
    .upper_half  (upper_half),
    .reg_sel     (reg_sel),
    .reg_bank    (reg_bank),
    .cycle_count (cycle_count),
    .digit_1     (digit_1),
    .digit_2     (digit_2),
    .digit_3     (digit_3),
    .digit_4     (digit_4),
    .digit_5     (digit_5),
    .digit_6     (digit_6),
    .leds        (leds)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (!reset) cycles_since_reset <= 0;
    else cycles_since_reset <= cycles_since_reset + 1;
  end

  // ************************************************************
  // Reference model and compare tasks
  // ************************************************************
  function automatic bit away_from_boundary(input int c, input int step_len);
    int pos;
    pos = (c - 1) % step_len;   // Output lags sequencer by one cycle
    return (pos != 0) && (pos != step_len - 1);
  endfunction

  task automatic check_glyph(input string name, input glyph_t expected, input glyph_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      row_errors++;
      $display("CHECK FAILED %s: expected %h, got %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic check_leds(input string name, input leds_t expected, input leds_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      row_errors++;
      $display("CHECK FAILED %s: expected %h, got %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic check_blank();
    check_glyph("digit_1", GLYPH_BLANK, digit_1);
    check_glyph("digit_2", GLYPH_BLANK, digit_2);
    check_glyph("digit_3", GLYPH_BLANK, digit_3);
    check_glyph("digit_4", GLYPH_BLANK, digit_4);
    check_glyph("digit_5", GLYPH_BLANK, digit_5);
    check_glyph("digit_6", GLYPH_BLANK, digit_6);
    check_leds("leds", '0, leds);
  endtask

  task automatic check_picture(input row_t r, input int c);
    word_t        src;
    logic [15:0]  half;
    banner_word_t word;
    if (r.run_mode) begin
      src  = r.show_cycles ? r.cycle_count : reg_bank[r.reg_sel];
      half = r.upper_half ? src[31:16] : src[15:0];
      check_glyph("digit_1", hex_glyph(half[3:0]), digit_1);
      check_glyph("digit_2", hex_glyph(half[7:4]), digit_2);
      check_glyph("digit_3", hex_glyph(half[11:8]), digit_3);
      check_glyph("digit_4", hex_glyph(half[15:12]), digit_4);
      if (r.show_cycles) begin
        check_glyph("digit_5", GLYPH_N, digit_5);
        check_glyph("digit_6", GLYPH_C, digit_6);
      end else begin
        check_glyph("digit_5", dec_glyph(4'(r.reg_sel % 10)), digit_5);   // Units
        check_glyph("digit_6", dec_glyph(4'(r.reg_sel / 10)), digit_6);   // Tens
      end
      if (away_from_boundary(c, LED_STEP))
        check_leds("leds", LED_WALK[((c - 1) / LED_STEP) % 10], leds);
    end else begin
      check_glyph("digit_1", GLYPH_BLANK, digit_1);
      check_glyph("digit_2", GLYPH_BLANK, digit_2);
      if (away_from_boundary(c, BANNER_STEP)) begin
        word = BANNER_WORDS[((c - 1) / BANNER_STEP) % 3];
        check_glyph("digit_3", word.d3, digit_3);
        check_glyph("digit_4", word.d4, digit_4);
        check_glyph("digit_5", word.d5, digit_5);
        check_glyph("digit_6", word.d6, digit_6);
      end
      if (away_from_boundary(c, LED_STEP))
        check_leds("leds", LED_SHOW[((c - 1) / LED_STEP) % 22], leds);
    end
  endtask

  // ************************************************************
  // Main sequence
  // ************************************************************
  initial begin
    int row;
    int h;
    int i;
    seed        = 32'h8ed8;
    reset       = 1'b0;
    run_mode    = 1'b0;
    show_cycles = 1'b0;
    upper_half  = 1'b0;
    reg_sel     = '0;
    cycle_count = '0;
    checks      = 0;
    errors      = 0;
    row_errors  = 0;
    for (i = 0; i < NUM_REGS; i++) reg_bank[i] = $random(seed);

    for (i = 0; i < 4; i++) begin
      @(posedge clk);
      #5;
      if (i == 3) reset = 1'b1;   // Released after 4 reset edges
      @(negedge clk);
      check_blank();
    end
    if (row_errors == 0) $display("reset: ok");
    else $display("reset: %0d errors", row_errors);

    for (row = 0; row < N_ROWS; row++) begin
      @(posedge clk);
      #5;
      run_mode    = ROWS[row].run_mode;
      show_cycles = ROWS[row].show_cycles;
      upper_half  = ROWS[row].upper_half;
      reg_sel     = ROWS[row].reg_sel;
      cycle_count = ROWS[row].cycle_count;
      row_errors  = 0;
      for (h = 0; h < ROWS[row].hold; h++) begin
        @(negedge clk);
        if (h >= 2) check_picture(ROWS[row], cycles_since_reset);   // Two-cycle latency
      end
      if (row_errors == 0) $display("row %0d: ok", row);
      else $display("row %0d: %0d errors", row, row_errors);
    end

    $display("%0d checks, %0d compare errors, %0d assertion failures",
             checks, errors, dut.u_mux.u_props.assert_failures);
    if (errors == 0 && dut.u_mux.u_props.assert_failures == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog sized from the stimulus table
  initial begin
    int limit;
    limit = 100;
    foreach (ROWS[i]) limit = limit + int'(ROWS[i].hold);
    #(limit * CLK_PERIOD);
    $display("Watchdog: run timed out after %0d cycles", limit);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* verilog.f */
logic/panel_pkg.sv
logic/panel_if.sv
logic/step_sequencer.sv
logic/readout_panel.sv
logic/banner_panel.sv
logic/panel_mux.sv
logic/debug_panel_top.sv
verif/debug_panel_properties.sv
verif/debug_panel_tb.sv

/* Bender.yml */
package:
  name: debug_panel

sources:
  - logic/panel_pkg.sv
  - logic/panel_if.sv
  - logic/step_sequencer.sv
  - logic/readout_panel.sv
  - logic/banner_panel.sv
  - logic/panel_mux.sv
  - logic/debug_panel_top.sv
  - target: test
    files:
      - verif/debug_panel_properties.sv
      - verif/debug_panel_tb.sv
